/* rtl/uart_pkg.sv */
`default_nettype none

package uart_pkg;

  // bit rate: clk / (TICK_DIVISOR * OVERSAMPLE)
  localparam int TICK_DIVISOR = 4;   // clk cycles per oversampling tick
  localparam int OVERSAMPLE   = 16;  // ticks per bit

  // frame layout: start, 8 data bits lsb first, one stop bit
  localparam int DATA_BITS  = 8;
  localparam int BIT_CYCLES = TICK_DIVISOR * OVERSAMPLE;
  localparam int FRAME_BITS = DATA_BITS + 2;

  // sender FSM states
  typedef enum logic [1:0] {
    TX_IDLE  = 2'b00,
    TX_START = 2'b01,
    TX_DATA  = 2'b10,
    TX_STOP  = 2'b11
  } tx_state_t;

endpackage

`default_nettype wire

/* rtl/baud_tick_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module baud_tick_gen
  import uart_pkg::*;
(
  input  logic clk,
  input  logic reset,
  output logic tick
);

  logic [$clog2(TICK_DIVISOR)-1:0] div_cnt;

  // free-running divider, restarts from zero when reset drops
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      div_cnt <= '0;
    end else if (div_cnt == $bits(div_cnt)'(TICK_DIVISOR - 1)) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // one cycle in TICK_DIVISOR, shared by both directions
  assign tick = (div_cnt == $bits(div_cnt)'(TICK_DIVISOR - 1));

endmodule

`default_nettype wire

/* rtl/uart_sender.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_sender
  import uart_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 tick,
  input  logic [DATA_BITS-1:0] tx_data,
  input  logic                 tx_enable,
  output logic                 uart_tx,
  output logic                 tx_busy
);

  tx_state_t            state;
  logic                 en_cur;      // tx_enable, first flop
  logic                 en_last;     // second flop
  logic                 en_rise;
  logic                 pending;     // one queued request
  logic [DATA_BITS-1:0] tx_buf;
  logic [6:0]           sample_cnt;  // [6:4] picks the data bit
  logic                 bit_end;     // last tick of a start or stop bit
  logic                 load;        // frame starts on this cycle

  assign en_rise = en_cur & ~en_last;
  assign bit_end = (sample_cnt == 7'(OVERSAMPLE - 1));

  // from idle the level must still be high, back to back frames only need the flag
  assign load = tick & pending &
                (((state == TX_IDLE) & tx_enable) | ((state == TX_STOP) & bit_end));

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state      <= TX_IDLE;
      sample_cnt <= '0;
      en_cur     <= 1'b0;
      en_last    <= 1'b0;
      pending    <= 1'b0;
      tx_busy    <= 1'b0;
    end else begin
      en_cur  <= tx_enable;
      en_last <= en_cur;

      // a new edge wins over the clear
      if (en_rise) begin
        pending <= 1'b1;
      end else if (tick && state == TX_STOP && sample_cnt == '0) begin
        pending <= 1'b0;
      end

      if (tick) begin
        unique case (state)
          TX_IDLE: begin
            if (load) begin
              state      <= TX_START;
              sample_cnt <= '0;
              tx_busy    <= 1'b1;
            end
          end
          TX_START: begin
            if (bit_end) begin
              state      <= TX_DATA;
              sample_cnt <= '0;
            end else begin
              sample_cnt <= sample_cnt + 7'd1;
            end
          end
          TX_DATA: begin
            if (sample_cnt == 7'(DATA_BITS * OVERSAMPLE - 1)) begin
              state      <= TX_STOP;
              sample_cnt <= '0;
            end else begin
              sample_cnt <= sample_cnt + 7'd1;
            end
          end
          TX_STOP: begin
            if (bit_end) begin
              sample_cnt <= '0;
              if (load) begin
                state <= TX_START;    // queued byte, no idle gap
              end else begin
                state   <= TX_IDLE;
                tx_busy <= 1'b0;
              end
            end else begin
              sample_cnt <= sample_cnt + 7'd1;
            end
          end
          default: state <= TX_IDLE;
        endcase
      end
    end
  end

  // byte is captured when a frame starts
  always_ff @(posedge clk) begin
    if (load) begin
      tx_buf <= tx_data;
    end
  end

  always_comb begin
    unique case (state)
      TX_START: uart_tx = 1'b0;
      TX_DATA:  uart_tx = tx_buf[sample_cnt[6:4]];
      default:  uart_tx = 1'b1;  // idle and stop
    endcase
  end

  a_idle_line_high: assert property (
    @(posedge clk) disable iff (reset) !tx_busy |-> uart_tx
  ) else $error("uart_tx low while sender not busy");

  a_busy_in_frame: assert property (
    @(posedge clk) disable iff (reset) (state inside {TX_START, TX_DATA}) |-> tx_busy
  ) else $error("tx_busy low during start or data");

endmodule

`default_nettype wire

/* rtl/uart_receiver.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_receiver
  import uart_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 tick,
  input  logic                 uart_rx,
  output logic [DATA_BITS-1:0] rx_data,
  output logic                 rx_valid,
  output logic                 rx_frame_error
);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_t;

  rx_state_t            state;
  logic                 rx_meta;
  logic                 rx_sync;
  logic                 rx_prev;     // for falling edge in idle
  logic [3:0]           sample_cnt;  // ticks within the current bit
  logic [2:0]           bit_cnt;
  logic [DATA_BITS-1:0] shift_reg;
  logic                 start_edge;
  logic                 mid_bit;     // middle of a data or stop bit
  logic                 sample_data;
  logic                 frame_done;

  assign start_edge  = rx_prev & ~rx_sync;
  assign mid_bit     = tick & (sample_cnt == 4'(OVERSAMPLE - 1));
  assign sample_data = mid_bit & (state == RX_DATA);
  assign frame_done  = mid_bit & (state == RX_STOP);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rx_meta        <= 1'b1;   // line idles high
      rx_sync        <= 1'b1;
      rx_prev        <= 1'b1;
      state          <= RX_IDLE;
      sample_cnt     <= '0;
      bit_cnt        <= '0;
      rx_valid       <= 1'b0;
      rx_frame_error <= 1'b0;
    end else begin
      rx_meta  <= uart_rx;
      rx_sync  <= rx_meta;
      rx_prev  <= rx_sync;
      rx_valid <= frame_done;

      unique case (state)
        RX_IDLE: begin
          // edge is checked every clk so a short tick gap cannot miss it
          if (start_edge) begin
            state      <= RX_START;
            sample_cnt <= '0;
          end
        end
        RX_START: begin
          if (tick) begin
            if (sample_cnt == 4'(OVERSAMPLE / 2 - 1)) begin
              sample_cnt <= '0;
              bit_cnt    <= '0;
              if (rx_sync) begin
                state <= RX_IDLE;   // glitch, not a start bit
              end else begin
                state <= RX_DATA;
              end
            end else begin
              sample_cnt <= sample_cnt + 4'd1;
            end
          end
        end
        RX_DATA: begin
          if (mid_bit) begin
            sample_cnt <= '0;
            if (bit_cnt == 3'(DATA_BITS - 1)) begin
              state <= RX_STOP;
            end else begin
              bit_cnt <= bit_cnt + 3'd1;
            end
          end else if (tick) begin
            sample_cnt <= sample_cnt + 4'd1;
          end
        end
        RX_STOP: begin
          if (mid_bit) begin
            state          <= RX_IDLE;
            sample_cnt     <= '0;
            rx_frame_error <= ~rx_sync;  // held until the next frame
          end else if (tick) begin
            sample_cnt <= sample_cnt + 4'd1;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // lsb arrives first, so shift in from the top
  always_ff @(posedge clk) begin
    if (sample_data) begin
      shift_reg <= {rx_sync, shift_reg[DATA_BITS-1:1]};
    end
    if (frame_done) begin
      rx_data <= shift_reg;
    end
  end

  a_valid_single: assert property (
    @(posedge clk) disable iff (reset) rx_valid |=> !rx_valid
  ) else $error("rx_valid held for more than one cycle");

endmodule

`default_nettype wire

/* rtl/uart_link_top.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_link_top
  import uart_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic [DATA_BITS-1:0] tx_data,
  input  logic                 tx_enable,
  input  logic                 uart_rx,
  output logic                 uart_tx,
  output logic                 tx_busy,
  output logic [DATA_BITS-1:0] rx_data,
  output logic                 rx_valid,
  output logic                 rx_frame_error
);

  logic tick;  // 16x oversampling enable, shared

  baud_tick_gen u_tick_gen (
    .clk   (clk),
    .reset (reset),
    .tick  (tick)
  );

  // tx and rx stay separate paths, the testbench closes the loop
  uart_sender u_sender (
    .clk       (clk),
    .reset     (reset),
    .tick      (tick),
    .tx_data   (tx_data),
    .tx_enable (tx_enable),
    .uart_tx   (uart_tx),
    .tx_busy   (tx_busy)
  );

  uart_receiver u_receiver (
    .clk            (clk),
    .reset          (reset),
    .tick           (tick),
    .uart_rx        (uart_rx),
    .rx_data        (rx_data),
    .rx_valid       (rx_valid),
    .rx_frame_error (rx_frame_error)
  );

endmodule

`default_nettype wire

/* tests/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  // reset held for 10 cycles, released on a rising edge
  initial begin
    reset = 1'b1;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

/* tests/tb_uart_link.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_uart_link
  import uart_pkg::*;
();

  localparam int N_TESTS      = 12;
  localparam int N_FIXED      = 8;
  localparam int FRAME_CYCLES = FRAME_BITS * BIT_CYCLES;
  localparam int WAIT_LIMIT   = 3 * FRAME_CYCLES;
  // queued pair sends two frames, so two frames per entry plus margin
  localparam int WATCHDOG_CYCLES = (2 * N_TESTS + 4) * FRAME_CYCLES;

  typedef enum int {M_IDLE, M_LOOP, M_QUEUE, M_DIRECT, M_GLITCH} mode_t;
  typedef struct {
    string      name;
    logic [7:0] data;
    mode_t      mode;
    bit         stop_good;
    logic [7:0] exp_data;
    bit         exp_ferr;
  } entry_t;

  logic                 clk;
  logic                 reset;
  logic [DATA_BITS-1:0] tx_data;
  logic                 tx_enable;
  logic                 uart_rx;
  logic                 uart_tx;
  logic                 tx_busy;
  logic [DATA_BITS-1:0] rx_data;
  logic                 rx_valid;
  logic                 rx_frame_error;
  logic                 loop_mode;  // uart_rx follows uart_tx
  logic                 bang_line;  // direct drive of uart_rx

  entry_t      stim [N_TESTS];
  logic [7:0]  got_data [$];
  bit          got_ferr [$];
  int          error_count;
  int          fail_tests;
  logic [31:0] rng_state;

  tb_clock_gen u_clk_gen (.clk(clk), .reset(reset));

  assign uart_rx = loop_mode ? uart_tx : bang_line;

  uart_link_top u_dut (
    .clk            (clk),
    .reset          (reset),
    .tx_data        (tx_data),
    .tx_enable      (tx_enable),
    .uart_rx        (uart_rx),
    .uart_tx        (uart_tx),
    .tx_busy        (tx_busy),
    .rx_data        (rx_data),
    .rx_valid       (rx_valid),
    .rx_frame_error (rx_frame_error)
  );

  // every received byte lands here
  always @(posedge clk) begin
    if (!reset && rx_valid) begin
      got_data.push_back(rx_data);
      got_ferr.push_back(rx_frame_error);
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic wait_busy(input string name, input logic level);
    int n;
    n = 0;
    while (tx_busy !== level && n < WAIT_LIMIT) begin
      @(posedge clk);
      n++;
    end
    if (tx_busy !== level) begin
      $display("%s: tx_busy did not go to %b in time", name, level);
      error_count++;
    end
  endtask

  // also reports whether tx_busy was low on any cycle of the wait
  task automatic wait_bytes(input string name, input int count, output bit busy_low);
    int n;
    n = 0;
    busy_low = 1'b0;
    while (got_data.size() < count && n < WAIT_LIMIT) begin
      @(posedge clk);
      if (tx_busy !== 1'b1) busy_low = 1'b1;
      n++;
    end
    if (got_data.size() < count) begin
      $display("%s: no byte arrived on rx_data in time", name);
      error_count++;
    end
  endtask

  task automatic bang_frame(input logic [7:0] data, input bit stop_good);
    logic [FRAME_BITS-1:0] bits;
    bits = {stop_good, data, 1'b0};  // start bit in bit 0, lsb first
    for (int b = 0; b < FRAME_BITS; b++) begin
      bang_line <= bits[b];
      repeat (BIT_CYCLES) @(posedge clk);
    end
    bang_line <= 1'b1;
  endtask

  task automatic run_test(input entry_t e);
    int         base;
    int         n_frames;
    bit         dropped;
    logic [7:0] exp;
    base     = got_data.size();
    n_frames = 0;
    case (e.mode)
      M_IDLE: begin
        if (uart_tx !== 1'b1) begin
          $display("CHECK FAILED %s: uart_tx expected 1 actual %b", e.name, uart_tx);
          error_count++;
        end
        if (tx_busy !== 1'b0) begin
          $display("CHECK FAILED %s: tx_busy expected 0 actual %b", e.name, tx_busy);
          error_count++;
        end
        repeat (FRAME_CYCLES) @(posedge clk);
      end
      M_LOOP, M_QUEUE: begin
        n_frames = (e.mode == M_QUEUE) ? 2 : 1;
        tx_data   <= e.data;
        tx_enable <= 1'b1;
        wait_busy(e.name, 1'b1);
        tx_enable <= 1'b0;
        if (e.mode == M_QUEUE) begin
          tx_data <= ~e.data;
          wait_bytes(e.name, base + 1, dropped);
          tx_enable <= 1'b1;  // first frame is in its stop bit now
          wait_bytes(e.name, base + 2, dropped);
          tx_enable <= 1'b0;
          if (dropped) begin
            $display("%s: tx_busy fell between the queued frames", e.name);
            error_count++;
          end
        end else begin
          wait_bytes(e.name, base + 1, dropped);
        end
        wait_busy(e.name, 1'b0);
      end
      M_DIRECT: begin
        n_frames = 1;
        loop_mode <= 1'b0;
        bang_frame(e.data, e.stop_good);
        wait_bytes(e.name, base + 1, dropped);
        loop_mode <= 1'b1;
      end
      default: begin
        loop_mode <= 1'b0;
        bang_line <= 1'b0;
        repeat (BIT_CYCLES / 4) @(posedge clk);  // well under half a bit
        bang_line <= 1'b1;
        repeat (FRAME_CYCLES) @(posedge clk);
        loop_mode <= 1'b1;
      end
    endcase
    if (got_data.size() != base + n_frames) begin
      $display("CHECK FAILED %s: byte count expected %0d actual %0d",
               e.name, n_frames, got_data.size() - base);
      error_count++;
    end else begin
      for (int k = 0; k < n_frames; k++) begin
        exp = (k == 0) ? e.exp_data : ~e.exp_data;  // queued byte is the inverse
        if (got_data[base + k] !== exp) begin
          $display("CHECK FAILED %s: rx_data expected %02h actual %02h",
                   e.name, exp, got_data[base + k]);
          error_count++;
        end
        if (got_ferr[base + k] !== e.exp_ferr) begin
          $display("CHECK FAILED %s: rx_frame_error expected %b actual %b",
                   e.name, e.exp_ferr, got_ferr[base + k]);
          error_count++;
        end
      end
    end
    if (rx_frame_error !== e.exp_ferr) begin
      $display("CHECK FAILED %s: rx_frame_error level expected %b actual %b",
               e.name, e.exp_ferr, rx_frame_error);
      error_count++;
    end
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    int errs_before;
    error_count = 0;
    fail_tests  = 0;
    rng_state   = 32'd84;
    tx_data   <= '0;
    tx_enable <= 1'b0;
    loop_mode <= 1'b1;
    bang_line <= 1'b1;
    // name, byte, mode, stop bit good, expected rx_data, expected frame error
    stim[0] = '{"idle_after_reset", 8'h00, M_IDLE,   1'b1, 8'h00, 1'b0};
    stim[1] = '{"loop_a5",          8'ha5, M_LOOP,   1'b1, 8'ha5, 1'b0};
    stim[2] = '{"loop_00",          8'h00, M_LOOP,   1'b1, 8'h00, 1'b0};
    stim[3] = '{"loop_ff",          8'hff, M_LOOP,   1'b1, 8'hff, 1'b0};
    stim[4] = '{"queued_pair",      8'h3c, M_QUEUE,  1'b1, 8'h3c, 1'b0};
    stim[5] = '{"direct_bad_stop",  8'h5a, M_DIRECT, 1'b0, 8'h5a, 1'b1};
    stim[6] = '{"direct_good_stop", 8'h81, M_DIRECT, 1'b1, 8'h81, 1'b0};
    stim[7] = '{"short_low_glitch", 8'h00, M_GLITCH, 1'b1, 8'h00, 1'b0};
    for (int i = N_FIXED; i < N_TESTS; i++) begin
      rng_state = xorshift32(rng_state);
      stim[i] = '{$sformatf("random_%0d", i - N_FIXED), rng_state[7:0], M_LOOP, 1'b1,
                  rng_state[7:0], 1'b0};
    end
    @(negedge reset);
    @(posedge clk);
    for (int i = 0; i < N_TESTS; i++) begin
      errs_before = error_count;
      run_test(stim[i]);
      if (error_count == errs_before) begin
        $display("test %0d %s: ok", i, stim[i].name);
      end else begin
        $display("test %0d %s: failed", i, stim[i].name);
        fail_tests++;
      end
      repeat (BIT_CYCLES) @(posedge clk);  // idle line between tests
    end
    $display("summary: %0d tests, %0d passed, %0d failed, %0d check errors",
             N_TESTS, N_TESTS - fail_tests, fail_tests, error_count);
    if (error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* uart_link.f */
rtl/uart_pkg.sv
rtl/baud_tick_gen.sv
rtl/uart_sender.sv
rtl/uart_receiver.sv
rtl/uart_link_top.sv
tests/tb_clock_gen.sv
tests/tb_uart_link.sv

/* Makefile */
TOP := tb_uart_link

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, fail unless the testbench passes"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f uart_link.f -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
		echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir
